/* source/isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// RV32 instruction format definitions used by the fetch stage
// major opcodes of the expanded 32-bit forms and the two views
// through which the predecoder reads a compressed half-word
//////////////////////////////////////////////////////////////////////

package isa_pkg;

  // major opcodes, bits [6:0] of a 32-bit instruction
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // CI layout
  // the register fields also serve CL (rs1'/rd') and CR (rd/rs2)
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } c_ci_t;

  // CJ layout
  // CR funct4 is {funct3, jimm[10]}
  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] jimm;
    logic [1:0]  op;
  } c_cj_t;

  // one half-word, decoded through both layouts at once
  typedef union packed {
    c_ci_t ci;
    c_cj_t cj;
  } c_instr_u;

endpackage

/* source/fetch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// fetch control types shared between the fetch stage blocks
// PC mux selects, configuration registers, queue entries and
// the IF/ID pipeline register seen by the decode stage
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // source of the next fetch address on a PC change
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_MRET,
    PC_FENCEI
  } pc_mux_e;

  // trap target, base for exceptions, vectored for interrupts
  typedef enum logic {
    EXC_BASE,
    EXC_IRQ
  } exc_mux_e;

  // configuration register addressed by a write
  typedef enum logic {
    CFG_BOOT,
    CFG_MTVEC
  } cfg_sel_e;

  typedef struct packed {
    logic [31:0] boot_addr;
    logic [23:0] mtvec;
  } fetch_cfg_t;

  // one prefetch queue entry
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } fetch_word_t;

  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        is_compressed;
    logic        illegal_c;
  } if_id_t;

endpackage

/* source/fetch_csr.sv */
//////////////////////////////////////////////////////////////////////
// fetch configuration registers: boot address and trap vector base
// written one register per strobe, vector base also loaded from
// the boot address when the core boots
//////////////////////////////////////////////////////////////////////

module fetch_csr #(
  parameter logic [31:0] BOOT_RESET = 32'h0000_0080
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_we_i,
  input  fetch_pkg::cfg_sel_e   cfg_sel_i,
  input  logic [31:0]           cfg_wdata_i,
  input  logic                  mtvec_init_i,
  output fetch_pkg::fetch_cfg_t cfg_o
);

  fetch_pkg::fetch_cfg_t cfg_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // boot address is word aligned
      cfg_q.boot_addr <= {BOOT_RESET[31:2], 2'b00};
      cfg_q.mtvec     <= '0;
    end
    else
    begin
      if (cfg_we_i && (cfg_sel_i == fetch_pkg::CFG_BOOT))
      begin
        cfg_q.boot_addr <= {cfg_wdata_i[31:2], 2'b00};
      end
      // boot-time init wins over a write in the same cycle
      if (mtvec_init_i)
      begin
        cfg_q.mtvec <= cfg_q.boot_addr[31:8];
      end
      else if (cfg_we_i && (cfg_sel_i == fetch_pkg::CFG_MTVEC))
      begin
        // vector base is 256-byte aligned, low byte dropped
        cfg_q.mtvec <= cfg_wdata_i[31:8];
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

/* source/pc_select.sv */
//////////////////////////////////////////////////////////////////////
// next fetch address selection on a PC change
// purely combinational, also requests the vector base init on boot
//////////////////////////////////////////////////////////////////////

module pc_select (
  input  fetch_pkg::fetch_cfg_t cfg_i,
  input  logic                  pc_set_i,
  input  fetch_pkg::pc_mux_e    pc_mux_i,
  input  fetch_pkg::exc_mux_e   exc_pc_mux_i,
  input  logic [4:0]            irq_id_i,
  input  logic [31:0]           jump_target_i,
  input  logic [31:0]           mepc_i,
  input  logic [31:0]           pc_id_i,
  output logic [31:0]           branch_addr_o,
  output logic                  mtvec_init_o
);

  logic [31:0] exc_pc;
  logic [31:0] next_pc;

  // trap vector
  always_comb
  begin
    case (exc_pc_mux_i)
      // interrupts land at base + 4 * irq id
      fetch_pkg::EXC_IRQ:
        exc_pc = {cfg_i.mtvec, 1'b0, irq_id_i, 2'b00};
      // all exceptions share the base address
      default:
        exc_pc = {cfg_i.mtvec, 8'h00};
    endcase
  end

  // fetch address mux
  always_comb
  begin
    case (pc_mux_i)
      fetch_pkg::PC_JUMP:      next_pc = jump_target_i;
      fetch_pkg::PC_EXCEPTION: next_pc = exc_pc;
      // restore the interrupted pc
      fetch_pkg::PC_MRET:      next_pc = mepc_i;
      // refetch from the word after the fence.i
      fetch_pkg::PC_FENCEI:    next_pc = pc_id_i + 32'd4;
      default:                 next_pc = cfg_i.boot_addr;
    endcase
  end

  // instruction addresses are always half-word aligned at least
  assign branch_addr_o = {next_pc[31:1], 1'b0};

  // first boot jump also initialises the vector base
  assign mtvec_init_o = pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

/* source/prefetch_buffer.sv */
//////////////////////////////////////////////////////////////////////
// prefetch buffer between the PC logic and the instruction memory
// issues sequential word fetches to a memory with a fixed one-cycle
// response, queues the returned words and flushes on a PC change
//////////////////////////////////////////////////////////////////////

module prefetch_buffer #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_en_i,
  input  logic                   branch_i,
  input  logic [31:0]            branch_addr_i,
  output logic                   imem_req_o,
  output logic [31:0]            imem_addr_o,
  input  logic                   imem_rvalid_i,
  input  logic [31:0]            imem_rdata_i,
  output logic                   queue_valid_o,
  output fetch_pkg::fetch_word_t queue_head_o,
  input  logic                   pop_i,
  output logic                   busy_o,
  output logic                   imiss_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [31:0]            fetch_addr_q;
  logic                   inflight_q;
  logic [31:0]            inflight_addr_q;
  logic                   kill_q;
  fetch_pkg::fetch_word_t queue_q [QUEUE_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic [CNT_W:0]         occupancy;
  logic                   push;

  // circular pointer step, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory request side
  //////////////////////////////////////////////////////////////////////

  // words queued plus the one still on its way
  assign occupancy  = count_q + inflight_q;
  assign imem_req_o = fetch_en_i && (occupancy < (CNT_W + 1)'(QUEUE_DEPTH));
  assign imem_addr_o = fetch_addr_q;

  // responses for the old path are thrown away
  assign push = imem_rvalid_i && !kill_q && !branch_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q <= '0;
      inflight_q   <= 1'b0;
      kill_q       <= 1'b0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
    end
    else
    begin
      // fixed latency, so at most one request is ever outstanding
      inflight_q <= imem_req_o;
      if (branch_i)
      begin
        fetch_addr_q <= branch_addr_i;
        // a request issued now answers next cycle, kill it
        kill_q       <= imem_req_o;
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
        count_q      <= '0;
      end
      else
      begin
        if (imem_req_o)
        begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (imem_rvalid_i)
        begin
          kill_q <= 1'b0;
        end
        if (push)
        begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_i)
        begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop_i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // remember where the outstanding word came from
    if (imem_req_o)
    begin
      inflight_addr_q <= imem_addr_o;
    end
    if (push)
    begin
      queue_q[wr_ptr_q] <= '{addr: inflight_addr_q, data: imem_rdata_i};
    end
  end

  assign queue_valid_o = (count_q != '0);
  assign queue_head_o  = queue_q[rd_ptr_q];

  // status for the core, only meaningful while fetching
  assign busy_o  = inflight_q || (fetch_en_i && (count_q != CNT_W'(QUEUE_DEPTH)));
  assign imiss_o = fetch_en_i && !branch_i && (count_q == '0);

  // every response must belong to the request of the cycle before
  a_rvalid_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    imem_rvalid_i |-> inflight_q)
    else $error("response without a request in flight");

  // request throttling must leave room for every accepted word
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count_q < CNT_W'(QUEUE_DEPTH)))
    else $error("prefetch queue overflow");

  // the predecoder only pops words it has been shown
  a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> queue_valid_o)
    else $error("pop on an empty prefetch queue");

endmodule

/* source/predecode_stage.sv */
//////////////////////////////////////////////////////////////////////
// predecode and IF/ID register
// expands the supported compressed forms, flags the others as
// illegal and hands the result to the decode stage on a pop
//////////////////////////////////////////////////////////////////////

module predecode_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   queue_valid_i,
  input  fetch_pkg::fetch_word_t queue_head_i,
  input  logic                   id_ready_i,
  input  logic                   halt_if_i,
  input  logic                   clear_instr_valid_i,
  output logic                   pop_o,
  output fetch_pkg::if_id_t      if_id_o
);

  isa_pkg::c_instr_u c_instr;
  logic [31:0]       raw;
  logic [4:0]        rd;
  logic [4:0]        rs2;
  logic [11:0]       ci_imm;
  logic [4:0]        lw_uimm;
  logic [19:0]       jal_imm;
  logic [31:0]       instr_exp;
  logic              is_comp;
  logic              illegal_c;

  //////////////////////////////////////////////////////////////////////
  // compressed expansion
  //////////////////////////////////////////////////////////////////////

  // compressed form sits in the low half, upper half ignored
  assign raw     = queue_head_i.data;
  assign c_instr = raw[15:0];
  assign rd      = c_instr.ci.rd_rs1;
  assign rs2     = c_instr.ci.imm_lo;

  // sign-extended 6-bit immediate of c.addi and c.li
  assign ci_imm = {{7{c_instr.ci.imm_hi}}, c_instr.ci.imm_lo};

  // c.lw offset bits [6:2]
  assign lw_uimm = {c_instr.ci.imm_lo[3], c_instr.ci.imm_hi,
                    c_instr.ci.rd_rs1[4:3], c_instr.ci.imm_lo[4]};

  // c.j offset scattered into the jal immediate layout
  assign jal_imm = {c_instr.cj.jimm[10], c_instr.cj.jimm[6], c_instr.cj.jimm[8:7],
                    c_instr.cj.jimm[4], c_instr.cj.jimm[5], c_instr.cj.jimm[0],
                    c_instr.cj.jimm[9], c_instr.cj.jimm[3:1],
                    c_instr.cj.jimm[10], {8{c_instr.cj.jimm[10]}}};

  always_comb
  begin
    // full-size words and illegal forms go through untouched
    instr_exp = raw;
    is_comp   = (c_instr.ci.op != 2'b11);
    illegal_c = is_comp;
    case ({c_instr.ci.op, c_instr.ci.funct3})
      // c.addi -> addi rd, rd, imm
      5'b01_000:
      begin
        instr_exp = {ci_imm, rd, 3'b000, rd, isa_pkg::OPC_OP_IMM};
        illegal_c = 1'b0;
      end
      // c.li -> addi rd, x0, imm
      5'b01_010:
      begin
        instr_exp = {ci_imm, 5'd0, 3'b000, rd, isa_pkg::OPC_OP_IMM};
        illegal_c = 1'b0;
      end
      // c.lw -> lw rd', uimm(rs1'), registers x8..x15
      5'b00_010:
      begin
        instr_exp = {5'b0, lw_uimm, 2'b00, 2'b01, c_instr.ci.rd_rs1[2:0], 3'b010,
                     2'b01, c_instr.ci.imm_lo[2:0], isa_pkg::OPC_LOAD};
        illegal_c = 1'b0;
      end
      // c.j -> jal x0, offset
      5'b01_101:
      begin
        instr_exp = {jal_imm, 5'd0, isa_pkg::OPC_JAL};
        illegal_c = 1'b0;
      end
      // CR group, rs2 of zero is c.jr/c.jalr/c.ebreak, not supported
      5'b10_100:
      begin
        if (rs2 != 5'd0)
        begin
          // funct4 low bit picks c.add over c.mv
          if (c_instr.cj.jimm[10])
          begin
            instr_exp = {7'b0, rs2, rd, 3'b000, rd, isa_pkg::OPC_OP};
          end
          else
          begin
            instr_exp = {7'b0, rs2, 5'd0, 3'b000, rd, isa_pkg::OPC_OP};
          end
          illegal_c = 1'b0;
        end
      end
      default:
      begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////////////////////////

  // take the head word when decode can accept it
  assign pop_o = queue_valid_i && id_ready_i && !halt_if_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      if_id_o <= '0;
    end
    else if (pop_o)
    begin
      if_id_o.instr_valid   <= 1'b1;
      if_id_o.pc            <= queue_head_i.addr;
      if_id_o.instr         <= instr_exp;
      if_id_o.is_compressed <= is_comp;
      if_id_o.illegal_c     <= illegal_c;
    end
    else if (clear_instr_valid_i)
    begin
      // payload stays, only the valid bit drops
      if_id_o.instr_valid <= 1'b0;
    end
  end

  // a new instruction only ever comes out of the prefetch queue
  a_valid_needs_pop: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(if_id_o.instr_valid) |-> $past(pop_o))
    else $error("instr_valid rose without a pop");

endmodule

/* source/fetch_stage.sv */
//////////////////////////////////////////////////////////////////////
// instruction fetch stage top level
// configuration, next-PC select, prefetch buffer and predecode,
// with the instruction memory and decode stage on the outside
//////////////////////////////////////////////////////////////////////

module fetch_stage #(
  parameter int          QUEUE_DEPTH = 2,
  parameter logic [31:0] BOOT_RESET  = 32'h0000_0080
) (
  input  logic                clk,
  input  logic                rst_n,
  // configuration writes
  input  logic                cfg_we_i,
  input  fetch_pkg::cfg_sel_e cfg_sel_i,
  input  logic [31:0]         cfg_wdata_i,
  // PC control from the core
  input  logic                fetch_en_i,
  input  logic                pc_set_i,
  input  fetch_pkg::pc_mux_e  pc_mux_i,
  input  fetch_pkg::exc_mux_e exc_pc_mux_i,
  input  logic [4:0]          irq_id_i,
  input  logic [31:0]         jump_target_i,
  input  logic [31:0]         mepc_i,
  // decode side
  input  logic                id_ready_i,
  input  logic                halt_if_i,
  input  logic                clear_instr_valid_i,
  output fetch_pkg::if_id_t   if_id_o,
  // instruction memory
  output logic                imem_req_o,
  output logic [31:0]         imem_addr_o,
  input  logic                imem_rvalid_i,
  input  logic [31:0]         imem_rdata_i,
  // status
  output logic                if_busy_o,
  output logic                perf_imiss_o
);

  fetch_pkg::fetch_cfg_t  cfg;
  fetch_pkg::fetch_word_t queue_head;
  logic                   mtvec_init;
  logic [31:0]            branch_addr;
  logic                   queue_valid;
  logic                   pop;
  logic                   queue_miss;

  fetch_csr #(
    .BOOT_RESET (BOOT_RESET)
  ) fetch_csr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .mtvec_init_i (mtvec_init),
    .cfg_o        (cfg)
  );

  // fence.i target comes from the pc now in IF/ID
  pc_select pc_select_i (
    .cfg_i         (cfg),
    .pc_set_i      (pc_set_i),
    .pc_mux_i      (pc_mux_i),
    .exc_pc_mux_i  (exc_pc_mux_i),
    .irq_id_i      (irq_id_i),
    .jump_target_i (jump_target_i),
    .mepc_i        (mepc_i),
    .pc_id_i       (if_id_o.pc),
    .branch_addr_o (branch_addr),
    .mtvec_init_o  (mtvec_init)
  );

  prefetch_buffer #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_rdata_i  (imem_rdata_i),
    .queue_valid_o (queue_valid),
    .queue_head_o  (queue_head),
    .pop_i         (pop),
    .busy_o        (if_busy_o),
    .imiss_o       (queue_miss)
  );

  predecode_stage predecode_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .queue_valid_i       (queue_valid),
    .queue_head_i        (queue_head),
    .id_ready_i          (id_ready_i),
    .halt_if_i           (halt_if_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .pop_o               (pop),
    .if_id_o             (if_id_o)
  );

  // a miss only counts while decode is actually waiting
  assign perf_imiss_o = queue_miss && id_ready_i && !halt_if_i;

endmodule

/* test/fetch_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the instruction fetch stage
// runs the steps of the pattern file against a one-cycle memory
// model and checks every instruction handed to decode, in order
//////////////////////////////////////////////////////////////////////

module fetch_tb;

  localparam int          QUEUE_DEPTH    = 2;
  localparam logic [31:0] BOOT_RESET     = 32'h0000_0080;
  localparam int          MAX_REC        = 64;
  localparam int          REC_W          = 5;
  localparam int          MEM_WORDS      = 4096;
  // run length allowed per line of the pattern file
  localparam int          CYCLES_PER_REC = 40;

  // one instruction as decode should see it
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        is_compressed;
    logic        illegal_c;
  } delivery_t;

  logic                clk;
  logic                rst_n;
  logic                cfg_we_i;
  fetch_pkg::cfg_sel_e cfg_sel_i;
  logic [31:0]         cfg_wdata_i;
  logic                fetch_en_i;
  logic                pc_set_i;
  fetch_pkg::pc_mux_e  pc_mux_i;
  fetch_pkg::exc_mux_e exc_pc_mux_i;
  logic [4:0]          irq_id_i;
  logic [31:0]         jump_target_i;
  logic [31:0]         mepc_i;
  logic                id_ready_i;
  logic                halt_if_i;
  logic                clear_instr_valid_i;
  fetch_pkg::if_id_t   if_id_o;
  logic                imem_req_o;
  logic [31:0]         imem_addr_o;
  logic                imem_rvalid_i;
  logic [31:0]         imem_rdata_i;
  logic                if_busy_o;
  logic                perf_imiss_o;

  logic [31:0] pat [MAX_REC*REC_W];
  logic [31:0] mem [MEM_WORDS];
  delivery_t   expected [$];
  int          seed        = 59121;
  int          n_rec       = 0;
  int          cycle_cnt   = 0;
  int          max_cycles  = 0;
  logic        stall_mode  = 1'b0;
  logic        rsp_pending = 1'b0;
  logic [31:0] rsp_addr    = '0;
  // words the prefetch queue should hold
  int          q_cnt       = 0;
  // response now on its way belongs to the old path
  logic        rsp_kill    = 1'b0;

  fetch_stage #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .BOOT_RESET  (BOOT_RESET)
  ) fetch_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cfg_we_i            (cfg_we_i),
    .cfg_sel_i           (cfg_sel_i),
    .cfg_wdata_i         (cfg_wdata_i),
    .fetch_en_i          (fetch_en_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .jump_target_i       (jump_target_i),
    .mepc_i              (mepc_i),
    .id_ready_i          (id_ready_i),
    .halt_if_i           (halt_if_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .if_id_o             (if_id_o),
    .imem_req_o          (imem_req_o),
    .imem_addr_o         (imem_addr_o),
    .imem_rvalid_i       (imem_rvalid_i),
    .imem_rdata_i        (imem_rdata_i),
    .if_busy_o           (if_busy_o),
    .perf_imiss_o        (perf_imiss_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cycle budget over the whole run
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (max_cycles > 0 && cycle_cnt >= max_cycles)
    begin
      $display("timeout after %0d cycles, expected instructions never arrived", cycle_cnt);
      $display("Test failed");
      $fatal(1, "run stopped on timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory model and checks
  //////////////////////////////////////////////////////////////////////

  // words outside the image, always full-size instructions
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b8b_4567) | 32'h3;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr >= 32'(MEM_WORDS * 4))
      return fill_word(addr);
    return mem[addr[13:2]];
  endfunction

  task automatic check_value(input logic [95:0] got, input logic [95:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // falling edge, strobes back to idle and the memory answers
  task automatic open_cycle();
    @(negedge clk);
    fetch_en_i          = 1'b1;
    pc_set_i            = 1'b0;
    cfg_we_i            = 1'b0;
    clear_instr_valid_i = 1'b0;
    id_ready_i          = 1'b0;
    halt_if_i           = 1'b0;
    // response to the request of the cycle before
    imem_rvalid_i = rsp_pending;
    imem_rdata_i  = rsp_pending ? read_word(rsp_addr) : 32'h0;
  endtask

  // sample just before the rising edge, check IF/ID after it
  task automatic close_cycle();
    logic              popped;
    logic              in_flight;
    fetch_pkg::if_id_t held;
    delivery_t         d;
    #40;
    // request of the cycle before is answered in this one
    in_flight = rsp_pending;
    popped    = id_ready_i && !halt_if_i && (q_cnt != 0);
    check_value(imem_req_o, (q_cnt + in_flight) < QUEUE_DEPTH, "imem_req_o");
    check_value(if_busy_o, in_flight || (q_cnt != QUEUE_DEPTH), "if_busy_o");
    check_value(perf_imiss_o, id_ready_i && !halt_if_i && !pc_set_i && (q_cnt == 0),
                "perf_imiss_o");
    if (pc_set_i)
    begin
      // flush, a request raised now answers on the old path
      q_cnt    = 0;
      rsp_kill = imem_req_o;
    end
    else
    begin
      if (in_flight && !rsp_kill)
        q_cnt++;
      if (popped)
        q_cnt--;
      rsp_kill = 1'b0;
    end
    rsp_pending = imem_req_o;
    rsp_addr    = imem_addr_o;
    held        = if_id_o;
    @(posedge clk);
    #10;
    if (popped && expected.size() == 0)
    begin
      $display("decode took an instruction that the pattern file does not list");
      $display("Test failed");
      $fatal(1, "unexpected delivery");
    end
    else if (popped)
    begin
      d = expected.pop_front();
      check_value(if_id_o.instr_valid, 1'b1, "instr_valid after a pop");
      check_value(if_id_o.pc, d.pc, "pc of delivered instruction");
      check_value(if_id_o.instr, d.instr, $sformatf("instr at pc %h", d.pc));
      check_value(if_id_o.is_compressed, d.is_compressed,
                  $sformatf("is_compressed at pc %h", d.pc));
      check_value(if_id_o.illegal_c, d.illegal_c, $sformatf("illegal_c at pc %h", d.pc));
    end
    else
    begin
      // clear drops the valid bit only
      if (clear_instr_valid_i)
        held.instr_valid = 1'b0;
      check_value(if_id_o, held, "IF/ID register without a pop");
    end
  endtask

  // let decode take every pending instruction, with random stalls if enabled
  task automatic drain_expected();
    logic [31:0] r;
    while (expected.size() > 0)
    begin
      open_cycle();
      id_ready_i = 1'b1;
      if (stall_mode)
      begin
        r          = $random(seed);
        id_ready_i = (r[1:0] != 2'b00);
        halt_if_i  = (r[4:2] == 3'b000);
      end
      close_cycle();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int        r;
    int        b;
    delivery_t d;
    rst_n               = 1'b0;
    cfg_we_i            = 1'b0;
    cfg_sel_i           = fetch_pkg::CFG_BOOT;
    cfg_wdata_i         = '0;
    fetch_en_i          = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = fetch_pkg::PC_BOOT;
    exc_pc_mux_i        = fetch_pkg::EXC_BASE;
    irq_id_i            = '0;
    jump_target_i       = '0;
    mepc_i              = '0;
    id_ready_i          = 1'b0;
    halt_if_i           = 1'b0;
    clear_instr_valid_i = 1'b0;
    imem_rvalid_i       = 1'b0;
    imem_rdata_i        = '0;

    // unused records read as the end marker
    foreach (pat[i])
      pat[i] = '0;
    $readmemh("test/fetch_patterns.txt", pat);
    while (n_rec < MAX_REC && pat[n_rec*REC_W] != '0)
      n_rec++;
    if (n_rec == 0)
    begin
      $display("the pattern file holds no steps");
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    max_cycles = CYCLES_PER_REC * n_rec;

    // memory image comes from the expect lines
    foreach (mem[i])
      mem[i] = fill_word(32'(i) << 2);
    for (r = 0; r < n_rec; r++)
    begin
      if (pat[r*REC_W] == 32'h4)
        mem[pat[r*REC_W+1][13:2]] = pat[r*REC_W+4];
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #40;
    check_value(imem_req_o, 1'b0, "imem_req_o after reset");
    check_value(if_id_o.instr_valid, 1'b0, "instr_valid after reset");
    check_value(if_busy_o, 1'b0, "if_busy_o after reset");
    check_value(perf_imiss_o, 1'b0, "perf_imiss_o after reset");

    for (r = 0; r < n_rec; r++)
    begin
      b = r * REC_W;
      if (pat[b] == 32'h4)
      begin
        d.pc            = pat[b+1];
        d.instr         = pat[b+2];
        d.is_compressed = pat[b+3][1];
        d.illegal_c     = pat[b+3][0];
        expected.push_back(d);
      end
      else
      begin
        drain_expected();
        case (pat[b])
          32'h2:
          begin
            open_cycle();
            cfg_we_i    = 1'b1;
            cfg_sel_i   = fetch_pkg::cfg_sel_e'(pat[b+1][0]);
            cfg_wdata_i = pat[b+2];
            close_cycle();
          end
          32'h3:
          begin
            // a core changes the PC with decode halted
            open_cycle();
            pc_set_i      = 1'b1;
            halt_if_i     = 1'b1;
            pc_mux_i      = fetch_pkg::pc_mux_e'(pat[b+1][2:0]);
            exc_pc_mux_i  = fetch_pkg::exc_mux_e'(pat[b+2][0]);
            irq_id_i      = pat[b+3][4:0];
            jump_target_i = pat[b+4];
            mepc_i        = pat[b+4];
            close_cycle();
          end
          32'h5:
            stall_mode = pat[b+1][0];
          32'h6:
          begin
            open_cycle();
            clear_instr_valid_i = 1'b1;
            close_cycle();
          end
          default:
          begin
            $display("unknown step kind %0h in line %0d of the pattern file", pat[b], r);
            $display("Test failed");
            $fatal(1, "bad pattern file");
          end
        endcase
      end
    end
    drain_expected();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* test/fetch_patterns.txt */
// kind a b c d in hex: 3 PC set (mux exc irq target), 4 expect (pc instr flags memword)
// 2 config write (sel wdata), 5 stall mode, 6 clear, 0 end; flags = {compressed, illegal}
// boot from the reset address, full and compressed words
3 0 0 0 0
4 80 00500093 0 00500093
4 84 00700113 2 abcd411d
4 88 ffd08093 2 000010f5
4 8c 002001b3 2 ffff818a
4 90 00320233 2 0000920e
4 94 00852483 2 12344504
4 98 0100006f 2 0000a801
4 9c 12348082 3 12348082
4 a0 cafe1000 3 cafe1000
// clear with no pop, then the stream resumes
6 0 0 0 0
4 a4 00208233 0 00208233
4 a8 00000013 0 00000013
// jump, then return from trap
3 1 0 0 200
4 200 00100513 0 00100513
4 204 00a50593 0 00a50593
3 3 0 0 300
4 300 40b50633 0 40b50633
// random ready and halt periods
5 1 0 0 0
3 1 0 0 400
4 400 00000093 0 00000093
4 404 00108113 0 00108113
4 408 00210193 0 00210193
4 40c 00318213 0 00318213
4 410 00420293 0 00420293
4 414 00528313 0 00528313
5 0 0 0 0
// vector base write, exception, vectored irq 5, fence.i
2 1 1000 0 0
3 2 0 0 0
4 1000 00000073 0 00000073
3 2 1 5 0
4 1014 00c00713 0 00c00713
4 1018 00170713 0 00170713
3 4 0 0 0
4 101c 0000100f 0 0000100f
// new boot address also reloads the vector base
2 0 2040 0 0
3 0 0 0 0
4 2040 00200513 0 00200513
3 2 0 0 0
4 2000 30200073 0 30200073
0 0 0 0 0

/* list.f */
source/isa_pkg.sv
source/fetch_pkg.sv
source/fetch_csr.sv
source/pc_select.sv
source/prefetch_buffer.sv
source/predecode_stage.sv
source/fetch_stage.sv
test/fetch_tb.sv
